// File: rv_defines.svh
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// data, address and instruction width
`define XLEN 32

// register index width and register count
`define REG_ADDR_W 5
`define NUM_REGS 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// shift amount taken from the low bits of operand b
`define SHAMT_W 5

`endif

// File: rv_pkg.sv
package rv_pkg;

    // major opcodes handled by the core
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        JAL    = 7'b1101111
    } opcode_e;

    // alu operations
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        AND    = 4'd2,
        OR     = 4'd3,
        XOR    = 4'd4,
        SLL    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        SLT    = 4'd8,
        PASS_B = 4'd9
    } alu_op_e;

    // immediate formats
    typedef enum logic [1:0] {
        IMM_I = 2'd0,
        IMM_S = 2'd1,
        IMM_U = 2'd2,
        IMM_J = 2'd3
    } imm_type_e;

    // source of the register write-back value
    // WB_LINK carries pc+4 for jal
    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_MEM  = 2'd1,
        WB_LINK = 2'd2
    } wb_sel_e;

endpackage

// File: fetch_unit.sv
`include "rv_defines.svh"

module fetch_unit (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              is_jal,
    input  logic [`XLEN-1:0]  imm,
    output logic [`XLEN-1:0]  pc,
    output logic [`XLEN-1:0]  pc_plus4,
    output logic              run
);

    logic [`XLEN-1:0] jal_target;
    logic [`XLEN-1:0] pc_next;

    assign pc_plus4   = pc + `XLEN'(4);
    assign jal_target = pc + imm;

    // jal is the only control transfer
    assign pc_next = is_jal ? jal_target : pc_plus4;

    // run rises one edge after reset release,
    // so the first fetch at the reset pc retires on the edge after that
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc  <= `RESET_PC;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (run) begin
                pc <= pc_next;
            end
        end
    end

endmodule

// File: decoder.sv
`include "rv_defines.svh"

module decoder (
    input  logic [`XLEN-1:0]        instr,
    input  logic                    run,
    output rv_pkg::alu_op_e         alu_op,
    output rv_pkg::imm_type_e       imm_type,
    output rv_pkg::wb_sel_e         wb_sel,
    output logic                    use_imm,
    output logic                    reg_we,
    output logic                    mem_we,
    output logic                    is_jal,
    output logic [`REG_ADDR_W-1:0]  rd,
    output logic [`REG_ADDR_W-1:0]  rs1,
    output logic [`REG_ADDR_W-1:0]  rs2
);

    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt_bit;
    alu_op_e    f3_alu_op;
    logic       f3_ok;
    logic       writes_rd;
    logic       is_store;

    assign opcode  = opcode_e'(instr[6:0]);
    assign rd      = instr[11:7];
    assign funct3  = instr[14:12];
    assign rs1     = instr[19:15];
    assign rs2     = instr[24:20];
    // funct7 bit 5, selects sub and sra
    assign alt_bit = instr[30];

    // alu operation shared by register and immediate forms
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            3'b000:  f3_alu_op = (alt_bit && opcode == OP) ? SUB : ADD;
            3'b001:  f3_alu_op = SLL;
            3'b010:  f3_alu_op = SLT;
            3'b100:  f3_alu_op = XOR;
            3'b101:  f3_alu_op = alt_bit ? SRA : SRL;
            3'b110:  f3_alu_op = OR;
            3'b111:  f3_alu_op = AND;
            // sltu and sltiu are not implemented
            default: begin
                f3_alu_op = ADD;
                f3_ok     = 1'b0;
            end
        endcase
    end

    always_comb begin
        alu_op    = ADD;
        imm_type  = IMM_I;
        wb_sel    = WB_ALU;
        use_imm   = 1'b0;
        writes_rd = 1'b0;
        is_store  = 1'b0;
        is_jal    = 1'b0;
        case (opcode)
            OP: begin
                alu_op    = f3_alu_op;
                writes_rd = f3_ok;
            end
            OP_IMM: begin
                alu_op    = f3_alu_op;
                use_imm   = 1'b1;
                writes_rd = f3_ok;
            end
            LUI: begin
                alu_op    = PASS_B;
                imm_type  = IMM_U;
                use_imm   = 1'b1;
                writes_rd = 1'b1;
            end
            LOAD: begin
                use_imm   = 1'b1;
                wb_sel    = WB_MEM;
                writes_rd = 1'b1;
            end
            STORE: begin
                imm_type  = IMM_S;
                use_imm   = 1'b1;
                is_store  = 1'b1;
            end
            JAL: begin
                imm_type  = IMM_J;
                wb_sel    = WB_LINK;
                writes_rd = 1'b1;
                is_jal    = 1'b1;
            end
            // anything else falls through as a no-op
            default: ;
        endcase
    end

    // x0 writes are dropped, nothing writes before the core runs
    assign reg_we = run && writes_rd && (rd != '0);
    assign mem_we = run && is_store;

endmodule

// File: imm_gen.sv
`include "rv_defines.svh"

module imm_gen (
    input  logic [`XLEN-1:0]   instr,
    input  rv_pkg::imm_type_e  imm_type,
    output logic [`XLEN-1:0]   imm
);

    import rv_pkg::*;

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_type)
            IMM_I: begin
                imm = {{(`XLEN-12){sign}}, instr[31:20]};
            end
            IMM_S: begin
                imm = {{(`XLEN-12){sign}}, instr[31:25], instr[11:7]};
            end
            IMM_U: begin
                imm = {instr[31:12], 12'b0};
            end
            // j offset is scattered and always even
            IMM_J: begin
                imm = {{(`XLEN-20){sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: reg_file.sv
`include "rv_defines.svh"

module reg_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic [`REG_ADDR_W-1:0]  rs1,
    input  logic [`REG_ADDR_W-1:0]  rs2,
    input  logic [`REG_ADDR_W-1:0]  rd,
    input  logic                    we,
    input  logic [`XLEN-1:0]        wdata,
    output logic [`XLEN-1:0]        rs1_data,
    output logic [`XLEN-1:0]        rs2_data
);

    // x0 has no storage
    logic [`XLEN-1:0] regs [1:`NUM_REGS-1];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

    // combinational reads, index 0 reads zero
    always_comb begin
        if (rs1 == '0) begin
            rs1_data = '0;
        end else begin
            rs1_data = regs[rs1];
        end
        if (rs2 == '0) begin
            rs2_data = '0;
        end else begin
            rs2_data = regs[rs2];
        end
    end

endmodule

// File: execute_unit.sv
`include "rv_defines.svh"

module execute_unit (
    input  logic [`XLEN-1:0]  rs1_data,
    input  logic [`XLEN-1:0]  rs2_data,
    input  logic [`XLEN-1:0]  imm,
    input  logic [`XLEN-1:0]  pc_plus4,
    input  logic [`XLEN-1:0]  dmem_rdata,
    input  rv_pkg::alu_op_e   alu_op,
    input  logic              use_imm,
    input  rv_pkg::wb_sel_e   wb_sel,
    output logic [`XLEN-1:0]  alu_result,
    output logic [`XLEN-1:0]  wb_data
);

    import rv_pkg::*;

    logic [`XLEN-1:0]    op_a;
    logic [`XLEN-1:0]    op_b;
    logic [`SHAMT_W-1:0] shamt;
    logic                less_than;

    assign op_a  = rs1_data;
    assign op_b  = use_imm ? imm : rs2_data;
    assign shamt = op_b[`SHAMT_W-1:0];

    // signed compare for slt and slti
    assign less_than = $signed(op_a) < $signed(op_b);

    always_comb begin
        case (alu_op)
            ADD: begin
                alu_result = op_a + op_b;
            end
            SUB: begin
                alu_result = op_a - op_b;
            end
            AND: begin
                alu_result = op_a & op_b;
            end
            OR: begin
                alu_result = op_a | op_b;
            end
            XOR: begin
                alu_result = op_a ^ op_b;
            end
            SLL: begin
                alu_result = op_a << shamt;
            end
            SRL: begin
                alu_result = op_a >> shamt;
            end
            SRA: begin
                alu_result = $unsigned($signed(op_a) >>> shamt);
            end
            SLT: begin
                alu_result = {{(`XLEN-1){1'b0}}, less_than};
            end
            // lui passes the u immediate straight through
            PASS_B: begin
                alu_result = op_b;
            end
            default: begin
                alu_result = op_a + op_b;
            end
        endcase
    end

    always_comb begin
        case (wb_sel)
            WB_MEM:  wb_data = dmem_rdata;
            WB_LINK: wb_data = pc_plus4;
            default: wb_data = alu_result;
        endcase
    end

endmodule

// File: rv_core.sv
`include "rv_defines.svh"

module rv_core (
    input  logic                    clk,
    input  logic                    arst_n,
    // instruction port
    output logic [`XLEN-1:0]        imem_addr,
    input  logic [`XLEN-1:0]        imem_data,
    // data port
    output logic [`XLEN-1:0]        dmem_addr,
    output logic [`XLEN-1:0]        dmem_wdata,
    output logic                    dmem_we,
    input  logic [`XLEN-1:0]        dmem_rdata,
    // retire port
    output logic                    wb_en,
    output logic [`REG_ADDR_W-1:0]  wb_rd,
    output logic [`XLEN-1:0]        wb_data
);

    import rv_pkg::*;

    logic [`XLEN-1:0]       pc;
    logic [`XLEN-1:0]       pc_plus4;
    logic                   run;
    logic [`XLEN-1:0]       imm;
    alu_op_e                alu_op;
    imm_type_e              imm_type;
    wb_sel_e                wb_sel;
    logic                   use_imm;
    logic                   reg_we;
    logic                   mem_we;
    logic                   is_jal;
    logic [`REG_ADDR_W-1:0] rd;
    logic [`REG_ADDR_W-1:0] rs1;
    logic [`REG_ADDR_W-1:0] rs2;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;

    fetch_unit fetch_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .is_jal   (is_jal),
        .imm      (imm),
        .pc       (pc),
        .pc_plus4 (pc_plus4),
        .run      (run)
    );

    decoder decoder_i (
        .instr    (imem_data),
        .run      (run),
        .alu_op   (alu_op),
        .imm_type (imm_type),
        .wb_sel   (wb_sel),
        .use_imm  (use_imm),
        .reg_we   (reg_we),
        .mem_we   (mem_we),
        .is_jal   (is_jal),
        .rd       (rd),
        .rs1      (rs1),
        .rs2      (rs2)
    );

    imm_gen imm_gen_i (
        .instr    (imem_data),
        .imm_type (imm_type),
        .imm      (imm)
    );

    reg_file reg_file_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .we       (reg_we),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    execute_unit execute_i (
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .imm        (imm),
        .pc_plus4   (pc_plus4),
        .dmem_rdata (dmem_rdata),
        .alu_op     (alu_op),
        .use_imm    (use_imm),
        .wb_sel     (wb_sel),
        .alu_result (dmem_addr),
        .wb_data    (wb_data)
    );

    assign imem_addr  = pc;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_we;
    // retire port mirrors the register write
    assign wb_en      = reg_we;
    assign wb_rd      = rd;

endmodule

// File: tb_rv_core.sv
`include "rv_defines.svh"

module tb_rv_core;

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic [`XLEN-1:0]       imem_addr;
    logic [`XLEN-1:0]       imem_data;
    logic [`XLEN-1:0]       dmem_addr;
    logic [`XLEN-1:0]       dmem_wdata;
    logic                   dmem_we;
    logic [`XLEN-1:0]       dmem_rdata;
    logic                   wb_en;
    logic [`REG_ADDR_W-1:0] wb_rd;
    logic [`XLEN-1:0]       wb_data;

    logic [31:0] imem [0:63];
    logic [31:0] dmem [0:63];
    logic [31:0] model_regs [0:31];
    logic [31:0] model_dmem [0:63];
    logic [31:0] model_pc;
    logic [31:0] end_addr;
    logic        running;
    logic        done;
    integer      seed;
    int          prog_len;
    int          checks;
    // expected response of the current instruction
    logic [31:0] exp_pc;
    logic [31:0] exp_data;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic [4:0]  exp_rd;
    logic        exp_we;
    logic        exp_st;

    rv_core dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data)
    );

    always #20 clk = ~clk;

    // memory models answer within the cycle
    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
        end
    end

    // same timing as the core's run flag
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            running <= 1'b0;
        end else begin
            running <= 1'b1;
        end
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                           input logic [11:0] imm, input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [4:0] rs1, rs2, input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [31:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input logic [31:0] instr);
        imem[prog_len] = instr;
        prog_len++;
    endtask

    // lui then addi with the upper part rounded for the signed low part
    task automatic load_const(input logic [4:0] rd, input logic [31:0] value);
        logic [31:0] upper;
        upper = (value + 32'h800) >> 12;
        emit({upper[19:0], rd, 7'b0110111});
        emit(i_type(3'b000, rd, rd, value[11:0], 7'b0010011));
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at time %0t: %s, got %h, expected %h",
                     $time, what, actual, expected);
            $display("Errors found");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    // executes one instruction on the model state
    function automatic void ref_step(input logic [31:0] instr, input logic [31:0] pc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic        writes;
        a         = model_regs[instr[19:15]];
        b         = model_regs[instr[24:20]];
        imm_i     = {{20{instr[31]}}, instr[31:20]};
        exp_pc    = pc + 32'd4;
        exp_data  = 32'd0;
        exp_st    = 1'b0;
        exp_addr  = 32'd0;
        exp_wdata = 32'd0;
        writes    = 1'b0;
        case (instr[6:0])
            7'b0110011: begin
                writes   = (instr[14:12] != 3'b011);
                exp_data = alu_ref(instr[14:12], instr[30], a, b);
            end
            7'b0010011: begin
                // bit 30 only matters for srai here
                writes   = (instr[14:12] != 3'b011);
                exp_data = alu_ref(instr[14:12], instr[30] && instr[14:12] == 3'b101, a, imm_i);
            end
            7'b0110111: begin
                writes   = 1'b1;
                exp_data = {instr[31:12], 12'b0};
            end
            7'b0000011: begin
                addr     = a + imm_i;
                writes   = 1'b1;
                exp_data = model_dmem[addr[7:2]];
            end
            7'b0100011: begin
                exp_st    = 1'b1;
                exp_addr  = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                exp_wdata = b;
                model_dmem[exp_addr[7:2]] = b;
            end
            7'b1101111: begin
                writes   = 1'b1;
                exp_data = pc + 32'd4;
                exp_pc   = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            default: ;
        endcase
        exp_rd = instr[11:7];
        exp_we = writes && exp_rd != 5'd0;
        if (exp_we) begin
            model_regs[exp_rd] = exp_data;
        end
    endfunction

    task automatic build_program();
        logic [31:0] a;
        logic [31:0] rnd;
        logic [31:0] k;
        prog_len = 0;
        a = $random(seed);
        load_const(5'd1, a | 32'h8000_0000);
        a = $random(seed);
        load_const(5'd2, a & 32'h7fff_ffff);
        load_const(5'd3, $random(seed));
        emit(r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd2));
        emit(r_type(7'h20, 3'b000, 5'd5, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b111, 5'd6, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b110, 5'd7, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b100, 5'd8, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b001, 5'd9, 5'd1, 5'd3));
        emit(r_type(7'h00, 3'b101, 5'd10, 5'd1, 5'd3));
        emit(r_type(7'h20, 3'b101, 5'd11, 5'd1, 5'd3));
        // x1 negative, x2 positive
        emit(r_type(7'h00, 3'b010, 5'd12, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b010, 5'd13, 5'd2, 5'd1));
        rnd = $random(seed);
        emit(i_type(3'b000, 5'd14, 5'd1, rnd[11:0], 7'b0010011));
        emit(i_type(3'b100, 5'd15, 5'd1, rnd[23:12], 7'b0010011));
        emit(i_type(3'b110, 5'd16, 5'd2, rnd[31:20], 7'b0010011));
        emit(i_type(3'b111, 5'd17, 5'd1, rnd[19:8], 7'b0010011));
        emit(i_type(3'b010, 5'd18, 5'd2, 12'hfff, 7'b0010011));
        emit(i_type(3'b010, 5'd19, 5'd1, 12'h005, 7'b0010011));
        emit(i_type(3'b001, 5'd20, 5'd1, {7'h00, rnd[4:0]}, 7'b0010011));
        emit(i_type(3'b101, 5'd21, 5'd1, {7'h00, rnd[9:5]}, 7'b0010011));
        emit(i_type(3'b101, 5'd22, 5'd1, {7'h20, rnd[14:10]}, 7'b0010011));
        // x0 as destination, then as source
        emit(r_type(7'h00, 3'b000, 5'd0, 5'd1, 5'd2));
        emit(r_type(7'h00, 3'b000, 5'd23, 5'd0, 5'd2));
        emit(i_type(3'b000, 5'd24, 5'd0, 12'h040, 7'b0010011));
        emit(s_type(5'd24, 5'd4, 12'd8));
        emit(i_type(3'b010, 5'd25, 5'd24, 12'd8, 7'b0000011));
        emit(i_type(3'b010, 5'd26, 5'd0, 12'h010, 7'b0000011));
        emit({17'h1abcd, 3'b000, 5'd5, 7'b1111111});
        // forward jal, backward jal, then jump to a self loop at the end
        k = 32'(prog_len * 4);
        emit(j_type(5'd27, 32'd12));
        emit(i_type(3'b000, 5'd29, 5'd0, 12'h055, 7'b0010011));
        emit(j_type(5'd0, 32'd8));
        emit(j_type(5'd30, 32'hffff_fff8));
        emit(j_type(5'd0, 32'd0));
        end_addr = k + 32'd16;
    endtask

    always @(negedge clk) begin
        if (!arst_n || !running) begin
            check_value(imem_addr, `RESET_PC, "imem_addr before the core runs");
            check_value(32'(wb_en), 32'd0, "wb_en before the core runs");
            check_value(32'(dmem_we), 32'd0, "dmem_we before the core runs");
        end else begin
            ref_step(imem[model_pc[7:2]], model_pc);
            check_value(imem_addr, model_pc, "imem_addr");
            check_value(32'(wb_en), 32'(exp_we), "wb_en");
            if (exp_we) begin
                check_value(32'(wb_rd), 32'(exp_rd), "wb_rd");
                check_value(wb_data, exp_data, "wb_data");
            end
            check_value(32'(dmem_we), 32'(exp_st), "dmem_we");
            if (exp_st) begin
                check_value(dmem_addr, exp_addr, "dmem_addr on store");
                check_value(dmem_wdata, exp_wdata, "dmem_wdata on store");
            end
            model_pc = exp_pc;
            checks++;
        end
    end

    initial begin
        arst_n   = 1'b0;
        seed     = 32'hd1e2;
        model_pc = `RESET_PC;
        checks   = 0;
        done     = 1'b0;
        for (int i = 0; i < 64; i++) begin
            // unknown opcode in every unused instruction slot
            imem[i]       = 32'((i * 4) << 7) | 32'h0000_007f;
            dmem[i]       = 32'h5a5a_0000 ^ 32'(i * 4);
            model_dmem[i] = dmem[i];
        end
        for (int i = 0; i < 32; i++) begin
            model_regs[i] = 32'd0;
        end
        build_program();
        repeat (5) @(posedge clk);
        #2 arst_n = 1'b1;
        for (int cycles = 0; cycles < 2000 && !done; cycles++) begin
            @(negedge clk);
            if (running && imem_addr == end_addr) begin
                done = 1'b1;
            end
        end
        @(posedge clk);
        if (done) begin
            $display("%0d instructions checked", checks);
            $display("No errors");
            $finish;
        end else begin
            $display("the program did not reach its end address within 2000 cycles");
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

endmodule

// File: rv_core.f
+incdir+.
rv_pkg.sv
fetch_unit.sv
decoder.sv
imm_gen.sv
reg_file.sv
execute_unit.sv
rv_core.sv
tb_rv_core.sv

// File: Makefile
TOP := tb_rv_core

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f rv_core.f

sim:
	verilator --binary --top-module $(TOP) -f rv_core.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "No errors" sim.log

clean:
	rm -rf obj_dir sim.log
